// ==== sim/rx_tests.txt ====
// columns, all hex: kind length exp_error d_frames d_errors d_crc_errors d_preamble_errors
// kind 0 good, 1 bad fcs, 2 rx_er in payload, 3 short, 4 bad sfd, 5 rx_er in preamble
0 0040 0 1 0 0 0    // good, minimum size
0 05EE 0 1 0 0 0    // good, maximum size
1 0040 1 1 1 1 0    // fcs corrupted
2 0080 1 1 1 1 0    // rx_er mid payload, byte garbled
3 0028 1 1 1 0 0    // runt, 40 bytes
4 0040 0 0 0 0 0    // wrong delimiter, no frame
5 0040 0 0 0 0 1    // rx_er inside preamble
0 0064 0 1 0 0 0
1 05EE 1 1 1 1 0
2 0040 1 1 1 1 0
3 000A 1 1 1 0 0    // dv drops inside the header
3 003F 1 1 1 0 0    // one byte short of minimum
4 00C8 0 0 0 0 0
5 0050 0 0 0 0 1
0 0041 0 1 0 0 0

// ==== filelist.f ====
+incdir+hdl
hdl/rx_mac_pkg.sv
hdl/rx_word_if.sv
hdl/gmii_rx_fsm.sv
hdl/crc32_check.sv
hdl/frame_assembler.sv
hdl/rx_stat_counters.sv
hdl/rx_mac_control.sv
sim/rx_checker.sv
sim/tb_rx_mac_control.sv

// ==== sim/tb_rx_mac_control.sv ====
`timescale 1ns/1ps
`include "rx_mac_defs.svh"

module tb_rx_mac_control;

    localparam int MAX_TESTS = 32;
    localparam int COLS      = 7;           // hex words per test line

    logic                 gmii_rx_clk;
    logic                 switch_rst_n;
    logic [7:0]           gmii_rx_data;
    logic                 gmii_rx_dv;
    logic                 gmii_rx_er;
    logic [7:0]           frame_data;
    logic                 frame_valid;
    logic                 frame_sof;
    logic                 frame_eof;
    logic                 frame_error;
    logic [`RX_LEN_W-1:0] frame_length;
    logic [31:0]          rx_frame_count;
    logic [31:0]          rx_error_count;
    logic [31:0]          crc_error_count;
    logic [31:0]          preamble_error_count;

    logic [15:0]          tests [0:MAX_TESTS*COLS-1];
    integer               seed;
    int                   frames_sent;      // frames that got past the sfd

    rx_mac_control UUT (
        .gmii_rx_clk          (gmii_rx_clk),
        .switch_rst_n         (switch_rst_n),
        .gmii_rx_data         (gmii_rx_data),
        .gmii_rx_dv           (gmii_rx_dv),
        .gmii_rx_er           (gmii_rx_er),
        .frame_data           (frame_data),
        .frame_valid          (frame_valid),
        .frame_sof            (frame_sof),
        .frame_eof            (frame_eof),
        .frame_error          (frame_error),
        .frame_length         (frame_length),
        .rx_frame_count       (rx_frame_count),
        .rx_error_count       (rx_error_count),
        .crc_error_count      (crc_error_count),
        .preamble_error_count (preamble_error_count)
    );

    rx_checker chk (
        .gmii_rx_clk          (gmii_rx_clk),
        .switch_rst_n         (switch_rst_n),
        .frame_data           (frame_data),
        .frame_valid          (frame_valid),
        .frame_sof            (frame_sof),
        .frame_eof            (frame_eof),
        .frame_error          (frame_error),
        .frame_length         (frame_length),
        .rx_frame_count       (rx_frame_count),
        .rx_error_count       (rx_error_count),
        .crc_error_count      (crc_error_count),
        .preamble_error_count (preamble_error_count)
    );

    initial begin
        gmii_rx_clk = 1'b0;
        forever #4 gmii_rx_clk = ~gmii_rx_clk;     // 125 MHz gmii
    end

    // reflected crc-32, lsb first, one bit per step
    function automatic logic [31:0] next_crc(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        int          k;
        c = crc ^ {24'd0, b};
        for (k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ `RX_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            0:       return "good";
            1:       return "bad fcs";
            2:       return "rx_er payload";
            3:       return "short";
            4:       return "bad sfd";
            5:       return "rx_er preamble";
            default: return "unknown";
        endcase
    endfunction

    task automatic drive_byte(input logic [7:0] d, input logic dv, input logic er);
        @(negedge gmii_rx_clk);
        gmii_rx_data = d;
        gmii_rx_dv   = dv;
        gmii_rx_er   = er;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_byte(8'h00, 1'b0, 1'b0);
    endtask

    // ======================================================================
    // one frame: preamble, sfd, random bytes, fcs, then the gap
    // ======================================================================

    task automatic send_frame(input int kind, input int len);
        logic [7:0]  frame [0:`RX_MAX_FRAME-1];
        logic [31:0] crc;
        logic [31:0] rnd;
        int          er_pos;
        int          i;
        crc    = `RX_CRC_INIT;
        er_pos = (kind == 2) ? len / 2 : -1;        // well inside the payload
        for (i = 0; i < len - 4; i++) begin
            rnd      = $random(seed);
            frame[i] = rnd[7:0];
            crc      = next_crc(crc, frame[i]);
        end
        crc = ~crc;                                 // fcs inverted, low byte first
        for (i = 0; i < 4; i++) frame[len-4+i] = crc[8*i +: 8];
        if (kind == 1) frame[len-4] = frame[len-4] ^ 8'h01;
        if (er_pos >= 0) frame[er_pos] = ~frame[er_pos];   // phy garbage under rx_er
        if (kind < 4) begin
            for (i = 0; i < len; i++) chk.push_byte(frame[i]);
        end
        for (i = 0; i < `RX_PREAMBLE_LEN; i++) begin
            drive_byte(`RX_PREAMBLE_BYTE, 1'b1, kind == 5 && i == 3);
        end
        drive_byte((kind == 4) ? 8'hD4 : `RX_SFD_BYTE, 1'b1, 1'b0);
        for (i = 0; i < len; i++) drive_byte(frame[i], 1'b1, i == er_pos);
        idle(`RX_IFG_LEN);
    endtask

    initial begin
        int t;
        int kind;
        int len;
        seed         = 45;
        frames_sent  = 0;
        gmii_rx_data = 8'h00;
        gmii_rx_dv   = 1'b0;
        gmii_rx_er   = 1'b0;
        switch_rst_n = 1'b0;
        for (t = 0; t < MAX_TESTS * COLS; t++) tests[t] = 16'hFFFF;   // end marker
        $readmemh("sim/rx_tests.txt", tests);
        repeat (4) @(posedge gmii_rx_clk);
        @(negedge gmii_rx_clk);
        chk.check_reset_values();
        switch_rst_n = 1'b1;
        idle(4);
        t = 0;
        while (t < MAX_TESTS && tests[t*COLS] != 16'hFFFF) begin
            kind = tests[t*COLS];
            len  = tests[t*COLS+1];
            chk.begin_test(kind_name(kind), len, tests[t*COLS+2][0], kind < 4,
                           tests[t*COLS+3], tests[t*COLS+4], tests[t*COLS+5], tests[t*COLS+6]);
            send_frame(kind, len);
            chk.finish_test();
            idle(4);                                // fsm leaves WAIT_IFG once dv is low
            if (kind < 4) frames_sent++;
            t++;
        end
        if (t == 0) chk.flag_problem("no tests were read from sim/rx_tests.txt");
        chk.check_frame_total(frames_sent);
        chk.print_summary();
        if (chk.error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/rx_checker.sv ====
`timescale 1ns/1ps
`include "rx_mac_defs.svh"

module rx_checker (
    input logic                 gmii_rx_clk,
    input logic                 switch_rst_n,
    input logic [7:0]           frame_data,
    input logic                 frame_valid,
    input logic                 frame_sof,
    input logic                 frame_eof,
    input logic                 frame_error,
    input logic [`RX_LEN_W-1:0] frame_length,
    input logic [31:0]          rx_frame_count,
    input logic [31:0]          rx_error_count,
    input logic [31:0]          crc_error_count,
    input logic [31:0]          preamble_error_count
);

    localparam int EOF_TIMEOUT = 64;            // cycles after the idle gap

    logic [7:0]           exp_bytes [$];        // bytes still to come out
    logic [`RX_LEN_W-1:0] exp_len;
    logic                 exp_err;
    logic                 exp_frame = 1'b0;     // test reaches the frame parser
    logic [31:0]          exp_delta [4];        // frames, errors, crc, preamble
    logic [31:0]          base [4];             // counter values at test start
    logic [7:0]           exp_b;
    string                test_name;
    int                   byte_idx;
    logic                 eof_seen;
    int                   test_errs   = 0;
    int                   test_num    = 0;
    int                   pass_count  = 0;
    int                   error_count = 0;

    function automatic logic [31:0] counter(input int i);
        case (i)
            0:       return rx_frame_count;
            1:       return rx_error_count;
            2:       return crc_error_count;
            default: return preamble_error_count;
        endcase
    endfunction

    function automatic string counter_name(input int i);
        case (i)
            0:       return "rx_frame_count";
            1:       return "rx_error_count";
            2:       return "crc_error_count";
            default: return "preamble_error_count";
        endcase
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        test_errs++;
        error_count++;
    endtask

    task automatic flag_problem(input string msg);
        $display("at %0t ns: %s", $time, msg);
        test_errs++;
        error_count++;
    endtask

    task automatic close_test();
        if (test_errs == 0) pass_count++;
        $display("test %0d %s: %s", test_num, test_name, (test_errs == 0) ? "ok" : "failed");
    endtask

    // ======================================================================
    // per test bookkeeping, called from the testbench top
    // ======================================================================

    task automatic begin_test(input string kind, input int len, input logic err,
                              input logic frame, input int d_frm, input int d_bad,
                              input int d_crc, input int d_pre);
        int i;
        test_num++;
        test_errs    = 0;
        test_name    = $sformatf("%s frame, %0d bytes", kind, len);
        exp_len      = len;
        exp_err      = err;
        exp_frame    = frame;
        exp_delta[0] = d_frm;
        exp_delta[1] = d_bad;
        exp_delta[2] = d_crc;
        exp_delta[3] = d_pre;
        for (i = 0; i < 4; i++) base[i] = counter(i);   // snapshot before preamble
        exp_bytes.delete();
        byte_idx = 0;
        eof_seen = 1'b0;
    endtask

    task automatic push_byte(input logic [7:0] b);
        exp_bytes.push_back(b);
    endtask

    task automatic finish_test();
        int waited;
        int i;
        waited = 0;
        if (exp_frame) begin
            while (!eof_seen && waited < EOF_TIMEOUT) begin
                @(negedge gmii_rx_clk);
                waited++;
            end
            if (!eof_seen) flag_problem("timed out waiting for frame_eof");
        end
        for (i = 0; i < 4; i++) begin
            if (counter(i) - base[i] !== exp_delta[i]) begin
                flag_mismatch($sformatf("%s moved by %0d, expected %0d", counter_name(i),
                                        counter(i) - base[i], exp_delta[i]));
            end
        end
        exp_frame = 1'b0;                       // anything after this is stray
        close_test();
    endtask

    task automatic check_reset_values();
        int i;
        test_num++;
        test_errs = 0;
        test_name = "reset values";
        if (frame_valid !== 1'b0 || frame_sof !== 1'b0 || frame_eof !== 1'b0) begin
            flag_mismatch("frame strobes not low in reset");
        end
        if (frame_error !== 1'b0) flag_mismatch("frame_error not low in reset");
        if (frame_length !== '0) flag_mismatch("frame_length not zero in reset");
        for (i = 0; i < 4; i++) begin
            if (counter(i) !== 32'd0) flag_mismatch($sformatf("%s not zero", counter_name(i)));
        end
        close_test();
    endtask

    task automatic check_frame_total(input int frames);
        test_num++;
        test_errs = 0;
        test_name = "frame total";
        if (rx_frame_count !== frames) begin
            flag_mismatch($sformatf("rx_frame_count %0d, expected %0d", rx_frame_count, frames));
        end
        close_test();
    endtask

    task automatic print_summary();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 test_num, pass_count, test_num - pass_count, error_count);
    endtask

    // ======================================================================
    // output monitor, outputs are settled by the falling edge
    // ======================================================================

    always @(negedge gmii_rx_clk) begin
        if (switch_rst_n) begin
            if (frame_valid) begin
                if (!exp_frame || exp_bytes.size() == 0) begin
                    flag_problem("frame_valid came with no byte expected");
                end else begin
                    exp_b = exp_bytes.pop_front();
                    if (frame_data !== exp_b) begin
                        flag_mismatch($sformatf("byte %0d is %h, expected %h",
                                                byte_idx, frame_data, exp_b));
                    end
                    if (frame_sof !== (byte_idx == 0)) begin    // sof on byte 0 only
                        flag_mismatch($sformatf("frame_sof %b on byte %0d", frame_sof, byte_idx));
                    end
                    byte_idx++;
                end
            end else if (frame_sof) begin
                flag_mismatch("frame_sof without frame_valid");
            end
            if (frame_eof) begin
                if (!exp_frame) begin
                    flag_problem("frame_eof came with no frame expected");
                end else begin
                    eof_seen = 1'b1;
                    if (frame_error !== exp_err) begin
                        flag_mismatch($sformatf("frame_error %b, expected %b",
                                                frame_error, exp_err));
                    end
                    if (frame_length !== exp_len) begin
                        flag_mismatch($sformatf("frame_length %0d, expected %0d",
                                                frame_length, exp_len));
                    end
                    if (exp_bytes.size() != 0) begin
                        flag_problem($sformatf("frame ended with %0d bytes never delivered",
                                               exp_bytes.size()));
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/rx_mac_control.sv ====
`timescale 1ns/1ps
`include "rx_mac_defs.svh"

module rx_mac_control (
    input  logic                 gmii_rx_clk,
    input  logic                 switch_rst_n,
    input  logic [7:0]           gmii_rx_data,
    input  logic                 gmii_rx_dv,
    input  logic                 gmii_rx_er,
    output logic [7:0]           frame_data,
    output logic                 frame_valid,
    output logic                 frame_sof,
    output logic                 frame_eof,
    output logic                 frame_error,
    output logic [`RX_LEN_W-1:0] frame_length,
    output logic [31:0]          rx_frame_count,
    output logic [31:0]          rx_error_count,
    output logic [31:0]          crc_error_count,
    output logic [31:0]          preamble_error_count
);

    logic crc_init, crc_en, crc_ok;
    logic frame_done, frame_bad, crc_bad, preamble_err;   // counter strobes

    rx_word_if word_if ();

    // ======================================================================
    // receive path
    // ======================================================================

    gmii_rx_fsm u_fsm (
        .gmii_rx_clk  (gmii_rx_clk),
        .switch_rst_n (switch_rst_n),
        .gmii_rx_data (gmii_rx_data),
        .gmii_rx_dv   (gmii_rx_dv),
        .gmii_rx_er   (gmii_rx_er),
        .crc_ok       (crc_ok),
        .crc_init     (crc_init),
        .crc_en       (crc_en),
        .frame_done   (frame_done),
        .frame_bad    (frame_bad),
        .crc_bad      (crc_bad),
        .preamble_err (preamble_err),
        .word_out     (word_if.src)
    );

    crc32_check u_crc (
        .gmii_rx_clk  (gmii_rx_clk),
        .switch_rst_n (switch_rst_n),
        .gmii_rx_data (gmii_rx_data),   // same byte the fsm forwards
        .crc_init     (crc_init),
        .crc_en       (crc_en),
        .crc_ok       (crc_ok)
    );

    frame_assembler u_asm (
        .gmii_rx_clk  (gmii_rx_clk),
        .switch_rst_n (switch_rst_n),
        .word_in      (word_if.dst),
        .frame_data   (frame_data),
        .frame_valid  (frame_valid),
        .frame_sof    (frame_sof),
        .frame_eof    (frame_eof),
        .frame_error  (frame_error),
        .frame_length (frame_length)
    );

    rx_stat_counters u_stats (
        .gmii_rx_clk          (gmii_rx_clk),
        .switch_rst_n         (switch_rst_n),
        .frame_done           (frame_done),
        .frame_bad            (frame_bad),
        .crc_bad              (crc_bad),
        .preamble_err         (preamble_err),
        .rx_frame_count       (rx_frame_count),
        .rx_error_count       (rx_error_count),
        .crc_error_count      (crc_error_count),
        .preamble_error_count (preamble_error_count)
    );

endmodule

// ==== hdl/rx_stat_counters.sv ====
`timescale 1ns/1ps

module rx_stat_counters (
    input  logic        gmii_rx_clk,
    input  logic        switch_rst_n,
    input  logic        frame_done,
    input  logic        frame_bad,
    input  logic        crc_bad,
    input  logic        preamble_err,
    output logic [31:0] rx_frame_count,
    output logic [31:0] rx_error_count,
    output logic [31:0] crc_error_count,
    output logic [31:0] preamble_error_count
);

    logic [3:0]  inc;           // one strobe per counter
    logic [31:0] cnt [4];

    assign inc = {preamble_err, crc_bad, frame_bad, frame_done};

    // ======================================================================
    // four free-running counters, wrap at 2^32
    // ======================================================================

    for (genvar i = 0; i < 4; i++) begin : g_cnt
        always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
            if (!switch_rst_n) begin
                cnt[i] <= 32'd0;
            end else if (inc[i]) begin
                cnt[i] <= cnt[i] + 32'd1;
            end
        end
    end

    assign rx_frame_count       = cnt[0];   // every frame that reached the header
    assign rx_error_count       = cnt[1];   // any error
    assign crc_error_count      = cnt[2];
    assign preamble_error_count = cnt[3];

endmodule

// ==== hdl/frame_assembler.sv ====
`timescale 1ns/1ps
`include "rx_mac_defs.svh"

module frame_assembler (
    input  logic                 gmii_rx_clk,
    input  logic                 switch_rst_n,
    rx_word_if.dst               word_in,
    output logic [7:0]           frame_data,
    output logic                 frame_valid,
    output logic                 frame_sof,
    output logic                 frame_eof,
    output logic                 frame_error,
    output logic [`RX_LEN_W-1:0] frame_length
);

    logic                            data_word;      // plain byte this cycle
    logic                            lo_pend;        // meta_lo seen, hi next
    logic                            eof_pend;
    logic                            err_q;
    logic [`RX_LEN_LO_W-1:0]         len_lo_q;
    logic [`RX_LEN_W-`RX_LEN_LO_W-1:0] len_hi_q;

    assign data_word = word_in.valid && !word_in.meta;

    // ======================================================================
    // control and outputs
    // ======================================================================

    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            frame_valid  <= 1'b0;
            frame_sof    <= 1'b0;
            frame_eof    <= 1'b0;
            frame_error  <= 1'b0;
            frame_length <= '0;
            lo_pend      <= 1'b0;
            eof_pend     <= 1'b0;
        end else begin
            frame_valid <= data_word;
            frame_sof   <= data_word && word_in.sof;
            if (word_in.valid && word_in.meta) lo_pend <= !lo_pend;
            eof_pend  <= word_in.valid && word_in.meta && lo_pend;  // hi half arrived
            frame_eof <= eof_pend;
            if (eof_pend) begin
                frame_error  <= err_q;                  // held until next eof
                frame_length <= {len_hi_q, len_lo_q};
            end
        end
    end

    // payload side, no reset
    always_ff @(posedge gmii_rx_clk) begin
        if (data_word) frame_data <= word_in.word.data;
        if (word_in.valid && word_in.meta && !lo_pend) begin
            err_q    <= word_in.word.meta_lo.err;
            len_lo_q <= word_in.word.meta_lo.len_lo;
        end
        if (word_in.valid && word_in.meta && lo_pend) len_hi_q <= word_in.word.meta_hi.len_hi;
    end

    a_meta_pair: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        (word_in.valid && word_in.meta && !lo_pend) |=> (word_in.valid && word_in.meta));

endmodule

// ==== hdl/crc32_check.sv ====
`timescale 1ns/1ps
`include "rx_mac_defs.svh"

module crc32_check (
    input  logic       gmii_rx_clk,
    input  logic       switch_rst_n,
    input  logic [7:0] gmii_rx_data,
    input  logic       crc_init,
    input  logic       crc_en,
    output logic       crc_ok
);
    import rx_mac_pkg::*;

    logic [31:0] crc_reg;

    // ======================================================================
    // running crc, seeded between frames
    // ======================================================================

    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            crc_reg <= `RX_CRC_INIT;
        end else if (crc_init) begin
            crc_reg <= `RX_CRC_INIT;
        end else if (crc_en) begin
            crc_reg <= crc32_step(crc_reg, gmii_rx_data);  // fcs runs through too
        end
    end

    // data + intact fcs always lands on the fixed residue
    assign crc_ok = (crc_reg == `RX_CRC_RESIDUE);

    // fsm only seeds in IDLE and only advances in HEADER/PAYLOAD
    a_init_en: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        !(crc_init && crc_en));

endmodule

// ==== hdl/gmii_rx_fsm.sv ====
`timescale 1ns/1ps
`include "rx_mac_defs.svh"

module gmii_rx_fsm (
    input  logic       gmii_rx_clk,
    input  logic       switch_rst_n,
    input  logic [7:0] gmii_rx_data,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    input  logic       crc_ok,
    output logic       crc_init,
    output logic       crc_en,
    output logic       frame_done,
    output logic       frame_bad,
    output logic       crc_bad,
    output logic       preamble_err,
    rx_word_if.src     word_out
);
    import rx_mac_pkg::*;

    rx_state_t              state, state_nx;
    logic [2:0]             pre_cnt, pre_cnt_nx;        // preamble bytes seen
    logic [`RX_LEN_W-1:0]   byte_cnt, byte_cnt_nx;      // forwarded bytes incl fcs
    logic [3:0]             ifg_cnt, ifg_cnt_nx;
    logic                   err, err_nx;                // sticky frame error
    logic                   fwd, fwd_sof;               // byte forwarded this cycle
    logic                   fwd_q, sof_q;
    logic [7:0]             byte_q;
    logic                   ifg_first, ifg_second;
    logic                   final_err;
    rx_word_u               meta_word;

    assign ifg_first  = (state == WAIT_IFG) && (ifg_cnt == 4'd0);
    assign ifg_second = (state == WAIT_IFG) && (ifg_cnt == 4'd1);
    assign final_err  = err || !crc_ok || (byte_cnt < `RX_MIN_FRAME);

    // ======================================================================
    // next state
    // ======================================================================

    always_comb begin
        state_nx    = state;
        pre_cnt_nx  = pre_cnt;
        byte_cnt_nx = byte_cnt;
        ifg_cnt_nx  = 4'd0;
        err_nx      = err;
        fwd         = 1'b0;
        fwd_sof     = 1'b0;
        case (state)
            IDLE: begin
                byte_cnt_nx = '0;
                err_nx      = 1'b0;
                if (gmii_rx_dv && !gmii_rx_er && gmii_rx_data == `RX_PREAMBLE_BYTE) begin
                    pre_cnt_nx = 3'd1;
                    state_nx   = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (gmii_rx_dv && !gmii_rx_er) begin
                    if (pre_cnt == `RX_PREAMBLE_LEN) begin
                        // sfd must follow the 7th byte
                        state_nx = (gmii_rx_data == `RX_SFD_BYTE) ? HEADER : IDLE;
                    end else if (gmii_rx_data == `RX_PREAMBLE_BYTE) begin
                        pre_cnt_nx = pre_cnt + 3'd1;
                    end else begin
                        state_nx = IDLE;                // bad byte, drop quietly
                    end
                end else begin
                    state_nx = IDLE;
                end
            end
            HEADER: begin
                if (gmii_rx_dv) begin
                    fwd         = 1'b1;
                    fwd_sof     = (byte_cnt == '0);
                    byte_cnt_nx = byte_cnt + 1'b1;
                    if (gmii_rx_er) err_nx = 1'b1;
                    if (byte_cnt == `RX_HEADER_LEN - 1) state_nx = PAYLOAD;
                end else begin
                    err_nx   = 1'b1;                    // truncated header
                    state_nx = WAIT_IFG;
                end
            end
            PAYLOAD: begin
                if (gmii_rx_dv) begin
                    if (byte_cnt == `RX_MAX_FRAME) begin
                        err_nx = 1'b1;                  // oversize, byte dropped
                    end else begin
                        fwd         = 1'b1;
                        byte_cnt_nx = byte_cnt + 1'b1;
                    end
                    if (gmii_rx_er) err_nx = 1'b1;
                end else begin
                    state_nx = WAIT_IFG;
                end
            end
            WAIT_IFG: begin
                if (ifg_first) err_nx = final_err;
                if (ifg_cnt == `RX_IFG_LEN - 1) begin
                    ifg_cnt_nx = ifg_cnt;
                    if (!gmii_rx_dv) state_nx = IDLE;   // never start mid-frame
                end else begin
                    ifg_cnt_nx = ifg_cnt + 4'd1;
                end
            end
            default: state_nx = IDLE;
        endcase
    end

    assign crc_init = (state == IDLE);
    assign crc_en   = fwd;                              // fcs bytes included

    // counter strobes, all from the first gap cycle
    assign frame_done   = ifg_first;
    assign frame_bad    = ifg_first && final_err;
    assign crc_bad      = ifg_first && !crc_ok;
    assign preamble_err = (state == PREAMBLE) && gmii_rx_er;

    // meta_lo in gap cycle 0, meta_hi in gap cycle 1
    always_comb begin
        meta_word.data = 8'h00;
        if (ifg_first) begin
            meta_word.meta_lo.err    = final_err;
            meta_word.meta_lo.len_lo = byte_cnt[`RX_LEN_LO_W-1:0];
        end else begin
            meta_word.meta_hi.len_hi = byte_cnt[`RX_LEN_W-1:`RX_LEN_LO_W];
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state          <= IDLE;
            pre_cnt        <= 3'd0;
            byte_cnt       <= '0;
            ifg_cnt        <= 4'd0;
            err            <= 1'b0;
            fwd_q          <= 1'b0;
            sof_q          <= 1'b0;
            word_out.valid <= 1'b0;
            word_out.sof   <= 1'b0;
            word_out.meta  <= 1'b0;
        end else begin
            state          <= state_nx;
            pre_cnt        <= pre_cnt_nx;
            byte_cnt       <= byte_cnt_nx;
            ifg_cnt        <= ifg_cnt_nx;
            err            <= err_nx;
            fwd_q          <= fwd;                      // first stage, byte held
            sof_q          <= fwd_sof;
            word_out.valid <= fwd_q || ifg_first || ifg_second;
            word_out.sof   <= sof_q;
            word_out.meta  <= ifg_first || ifg_second;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (fwd) byte_q <= gmii_rx_data;
        if (ifg_first || ifg_second) begin
            word_out.word <= meta_word;
        end else begin
            word_out.word.data <= byte_q;
        end
    end

    // data words come from HEADER/PAYLOAD two edges back, meta words from the
    // first two gap cycles one edge back
    a_word_src: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        word_out.valid |-> (word_out.meta
            ? ($past(state) == WAIT_IFG && $past(ifg_cnt) < 4'd2)
            : ($past(state, 2) inside {HEADER, PAYLOAD})));

    a_max_len: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        byte_cnt <= `RX_MAX_FRAME);

endmodule

// ==== hdl/rx_word_if.sv ====
`timescale 1ns/1ps

interface rx_word_if;
    import rx_mac_pkg::*;

    logic     valid;    // one strobe per word
    logic     sof;      // first header byte
    logic     meta;     // word is metadata, lo then hi
    rx_word_u word;

    modport src (output valid, output sof, output meta, output word);
    modport dst (input valid, input sof, input meta, input word);

endinterface

// ==== hdl/rx_mac_pkg.sv ====
`include "rx_mac_defs.svh"

package rx_mac_pkg;

    // receive fsm states
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,     // dest addr, src addr, ethertype
        PAYLOAD,    // payload and fcs, cut through
        WAIT_IFG
    } rx_state_t;

    // one word on the internal path is a data byte or one half of
    // the end-of-frame metadata (error + length)
    typedef union packed {
        logic [7:0] data;
        struct packed {
            logic                        err;
            logic [`RX_LEN_LO_W-1:0]     len_lo;
        } meta_lo;
        struct packed {
            logic [7-(`RX_LEN_W-`RX_LEN_LO_W):0] pad;
            logic [`RX_LEN_W-`RX_LEN_LO_W-1:0]   len_hi;
        } meta_hi;
    } rx_word_u;

    // one byte of crc-32 into an msb-first register with the byte reflected
    // since gmii sends lsb first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc_in,
                                                input logic [7:0]  data);
        logic [31:0] crc;
        logic [31:0] poly;
        logic [31:0] poly_msb;
        logic [7:0]  data_rev;
        poly = `RX_CRC_POLY;
        for (int i = 0; i < 8; i++) data_rev[i] = data[7-i];
        for (int i = 0; i < 32; i++) poly_msb[i] = poly[31-i];   // 0x04C11DB7
        crc = crc_in ^ {data_rev, 24'h00_0000};
        for (int i = 0; i < 8; i++) begin
            crc = crc[31] ? ((crc << 1) ^ poly_msb) : (crc << 1);
        end
        return crc;
    endfunction

endpackage

// ==== hdl/rx_mac_defs.svh ====
`ifndef RX_MAC_DEFS_SVH
`define RX_MAC_DEFS_SVH

// ==========================================================================
// ethernet framing constants
// ==========================================================================

`define RX_PREAMBLE_BYTE 8'h55  // repeated RX_PREAMBLE_LEN times
`define RX_SFD_BYTE      8'hD5  // start frame delimiter
`define RX_PREAMBLE_LEN  7

// frame size counted from dest addr through fcs
`define RX_MIN_FRAME     64
`define RX_MAX_FRAME     1518   // no vlan tag
`define RX_HEADER_LEN    14     // dst + src + ethertype
`define RX_IFG_LEN       12     // gap cycles after dv drops

// length field, split over two metadata words
`define RX_LEN_W         11
`define RX_LEN_LO_W      7

// ==========================================================================
// crc-32, reflected polynomial form
// ==========================================================================

`define RX_CRC_INIT      32'hFFFF_FFFF
`define RX_CRC_POLY      32'hEDB8_8320
`define RX_CRC_RESIDUE   32'hC704_DD7B  // register value after data + good fcs

`endif
